// ==== common/csr_pkg.sv ====
package csr_pkg;

    // Width types
    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [29:0] timer_init_t;

    // CSR numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // Exception codes
    localparam ecode_t    ECODE_ADE      = 6'h8;
    localparam ecode_t    ECODE_ALE      = 6'h9;
    localparam esubcode_t ESUBCODE_ADEF  = 9'h0;

    // ESTAT.IS positions of the internal interrupt sources
    localparam int INT_TIMER_BIT = 11;
    localparam int INT_IPI_BIT   = 12;

    // Counter value once a one-shot countdown has expired
    localparam word_t TIMER_STOPPED = 32'hffff_ffff;

    typedef struct packed {
        logic     we;
        csr_num_t num;
        word_t    wmask;
        word_t    wvalue;
    } csr_write_t;

    // Exception committed at writeback
    typedef struct packed {
        logic      valid;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
        word_t     vaddr;
    } exc_event_t;

    // Field order follows the CRMD bit layout, PLV in bits 1:0
    typedef struct packed {
        logic pg;
        logic da;
        logic ie;
        plv_t plv;
    } crmd_t;

    localparam crmd_t CRMD_RESET = '{pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'd0};

    // Bits set in the mask take the new value, the rest keep the old one
    function automatic word_t masked_write(word_t old_value, word_t wmask, word_t wvalue);
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

// ==== design/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*;
(
    input  csr_num_t    num,
    input  crmd_t       crmd,
    input  plv_t        prmd_pplv,
    input  logic        prmd_pie,
    input  int_vec_t    ecfg_lie,
    input  int_vec_t    estat_is,
    input  ecode_t      estat_ecode,
    input  esubcode_t   estat_esubcode,
    input  word_t       era,
    input  word_t       badv,
    input  word_t       eentry,
    input  word_t       save0,
    input  word_t       save1,
    input  word_t       save2,
    input  word_t       save3,
    input  word_t       tid,
    input  logic        tcfg_en,
    input  logic        tcfg_periodic,
    input  timer_init_t tcfg_init,
    input  word_t       tval,
    output word_t       rvalue
);

    always_comb
    begin
        case (num)
            CSR_CRMD:   rvalue = {27'b0, crmd};
            CSR_PRMD:   rvalue = {29'b0, prmd_pie, prmd_pplv};
            CSR_ECFG:   rvalue = {19'b0, ecfg_lie};
            CSR_ESTAT:  rvalue = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            CSR_ERA:    rvalue = era;
            CSR_BADV:   rvalue = badv;
            CSR_EENTRY: rvalue = eentry;
            CSR_SAVE0:  rvalue = save0;
            CSR_SAVE1:  rvalue = save1;
            CSR_SAVE2:  rvalue = save2;
            CSR_SAVE3:  rvalue = save3;
            CSR_TID:    rvalue = tid;
            CSR_TCFG:   rvalue = {tcfg_init, tcfg_periodic, tcfg_en};
            CSR_TVAL:   rvalue = tval;
            // Clear bit is write-only
            CSR_TICLR:  rvalue = '0;
            default:    rvalue = '0;
        endcase
    end

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit import csr_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  csr_write_t csr_wr,
    output word_t      csr_rvalue,
    input  exc_event_t exc,
    input  logic       ertn_flush,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    output logic       has_int,
    output word_t      ex_entry
);

    crmd_t       crmd;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    word_t       era;
    word_t       badv;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       eentry;
    int_vec_t    ecfg_lie;
    int_vec_t    estat_is;
    word_t       tid;
    logic        tcfg_en;
    logic        tcfg_periodic;
    timer_init_t tcfg_init;
    word_t       tval;
    logic        timer_zero;
    word_t       save0;
    word_t       save1;
    word_t       save2;
    word_t       save3;

    exc_state i_exc_state (
        .clock          (clock),
        .reset          (reset),
        .csr_wr         (csr_wr),
        .exc            (exc),
        .ertn_flush     (ertn_flush),
        .crmd           (crmd),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .era            (era),
        .badv           (badv),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .eentry         (eentry)
    );

    assign ex_entry = eentry;

    int_ctrl i_int_ctrl (
        .clock      (clock),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .crmd_ie    (crmd.ie),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .timer_zero (timer_zero),
        .ecfg_lie   (ecfg_lie),
        .estat_is   (estat_is),
        .has_int    (has_int)
    );

    stable_timer i_stable_timer (
        .clock         (clock),
        .reset         (reset),
        .csr_wr        (csr_wr),
        .tid           (tid),
        .tcfg_en       (tcfg_en),
        .tcfg_periodic (tcfg_periodic),
        .tcfg_init     (tcfg_init),
        .tval          (tval),
        .timer_zero    (timer_zero)
    );

    save_regs i_save_regs (
        .clock  (clock),
        .csr_wr (csr_wr),
        .save0  (save0),
        .save1  (save1),
        .save2  (save2),
        .save3  (save3)
    );

    csr_read_mux i_csr_read_mux (
        .num            (csr_wr.num),
        .crmd           (crmd),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era            (era),
        .badv           (badv),
        .eentry         (eentry),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .tid            (tid),
        .tcfg_en        (tcfg_en),
        .tcfg_periodic  (tcfg_periodic),
        .tcfg_init      (tcfg_init),
        .tval           (tval),
        .rvalue         (csr_rvalue)
    );

endmodule

// ==== design/int_ctrl.sv ====
`timescale 1ns/1ps

module int_ctrl import csr_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  csr_write_t csr_wr,
    input  logic       crmd_ie,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    input  logic       timer_zero,
    output int_vec_t   ecfg_lie,
    output int_vec_t   estat_is,
    output logic       has_int
);

    logic  ecfg_wr;
    logic  estat_wr;
    logic  ticlr_clr;
    word_t ecfg_merged;
    word_t is_merged;

    assign ecfg_wr  = csr_wr.we && csr_wr.num == CSR_ECFG;
    assign estat_wr = csr_wr.we && csr_wr.num == CSR_ESTAT;
    assign ticlr_clr = csr_wr.we && csr_wr.num == CSR_TICLR
                    && csr_wr.wmask[0] && csr_wr.wvalue[0];

    assign ecfg_merged = masked_write({19'b0, ecfg_lie}, csr_wr.wmask, csr_wr.wvalue);
    assign is_merged   = masked_write({19'b0, estat_is}, csr_wr.wmask, csr_wr.wvalue);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            ecfg_lie <= '0;
        end
        else if (ecfg_wr)
        begin
            ecfg_lie <= ecfg_merged[12:0];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            estat_is <= '0;
        end
        else
        begin
            // Only the two software bits are writable
            if (estat_wr)
            begin
                estat_is[1:0] <= is_merged[1:0];
            end
            estat_is[9:2] <= hw_int_in;
            estat_is[10]  <= 1'b0;
            if (timer_zero)
            begin
                estat_is[INT_TIMER_BIT] <= 1'b1;
            end
            else if (ticlr_clr)
            begin
                estat_is[INT_TIMER_BIT] <= 1'b0;
            end
            estat_is[INT_IPI_BIT] <= ipi_int_in;
        end
    end

    assign has_int = (|(estat_is[11:0] & ecfg_lie[11:0])) && crmd_ie;

endmodule

// ==== design/save_regs.sv ====
`timescale 1ns/1ps

module save_regs import csr_pkg::*;
(
    input  logic       clock,
    input  csr_write_t csr_wr,
    output word_t      save0,
    output word_t      save1,
    output word_t      save2,
    output word_t      save3
);

    word_t save_q [4];

    // SAVE0 to SAVE3 occupy consecutive numbers
    always_ff @(posedge clock)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (csr_wr.we && csr_wr.num == CSR_SAVE0 + csr_num_t'(i))
            begin
                save_q[i] <= masked_write(save_q[i], csr_wr.wmask, csr_wr.wvalue);
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== exception/exc_state.sv ====
`timescale 1ns/1ps

module exc_state import csr_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  csr_write_t csr_wr,
    input  exc_event_t exc,
    input  logic       ertn_flush,
    output crmd_t      crmd,
    output plv_t       prmd_pplv,
    output logic       prmd_pie,
    output word_t      era,
    output word_t      badv,
    output ecode_t     estat_ecode,
    output esubcode_t  estat_esubcode,
    output word_t      eentry
);

    logic        wr_ok;
    logic        addr_err;
    logic [25:0] eentry_va;
    word_t       crmd_merged;
    word_t       prmd_merged;
    word_t       eentry_merged;

    // Exception first, then ertn, then a software write
    assign wr_ok = csr_wr.we && !exc.valid && !ertn_flush;

    assign addr_err = (exc.ecode == ECODE_ADE) || (exc.ecode == ECODE_ALE);

    assign crmd_merged   = masked_write({27'b0, crmd}, csr_wr.wmask, csr_wr.wvalue);
    assign prmd_merged   = masked_write({29'b0, prmd_pie, prmd_pplv},
                                        csr_wr.wmask, csr_wr.wvalue);
    assign eentry_merged = masked_write(eentry, csr_wr.wmask, csr_wr.wvalue);

    assign eentry = {eentry_va, 6'b0};

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            crmd <= CRMD_RESET;
        end
        else if (exc.valid)
        begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end
        else if (ertn_flush)
        begin
            crmd.plv <= prmd_pplv;
            crmd.ie  <= prmd_pie;
        end
        else if (wr_ok && csr_wr.num == CSR_CRMD)
        begin
            crmd <= crmd_t'(crmd_merged[4:0]);
        end
    end

    // Saved context, no reset
    always_ff @(posedge clock)
    begin
        if (exc.valid)
        begin
            prmd_pplv <= crmd.plv;
            prmd_pie  <= crmd.ie;
        end
        else if (wr_ok && csr_wr.num == CSR_PRMD)
        begin
            prmd_pplv <= prmd_merged[1:0];
            prmd_pie  <= prmd_merged[2];
        end
    end

    always_ff @(posedge clock)
    begin
        if (exc.valid)
        begin
            era <= exc.pc;
        end
        else if (wr_ok && csr_wr.num == CSR_ERA)
        begin
            era <= masked_write(era, csr_wr.wmask, csr_wr.wvalue);
        end
    end

    always_ff @(posedge clock)
    begin
        if (exc.valid)
        begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
        end
    end

    // Fetch address errors report the pc, data errors the access address
    always_ff @(posedge clock)
    begin
        if (exc.valid && addr_err)
        begin
            if (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF)
            begin
                badv <= exc.pc;
            end
            else
            begin
                badv <= exc.vaddr;
            end
        end
        else if (wr_ok && csr_wr.num == CSR_BADV)
        begin
            badv <= masked_write(badv, csr_wr.wmask, csr_wr.wvalue);
        end
    end

    always_ff @(posedge clock)
    begin
        if (wr_ok && csr_wr.num == CSR_EENTRY)
        begin
            eentry_va <= eentry_merged[31:6];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CSR unit testbench with Verilator, runs it and checks sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_csr_unit \
    -f verilog.f -o sim_csr_unit > build.log 2>&1 \
    && ./obj_dir/sim_csr_unit > sim.log 2>&1 \
    && cat sim.log \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation passed"
exit 0

// ==== timer/stable_timer.sv ====
`timescale 1ns/1ps

module stable_timer import csr_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  csr_write_t  csr_wr,
    output word_t       tid,
    output logic        tcfg_en,
    output logic        tcfg_periodic,
    output timer_init_t tcfg_init,
    output word_t       tval,
    output logic        timer_zero
);

    logic  tid_wr;
    logic  tcfg_wr;
    word_t tcfg_merged;
    word_t count;

    assign tid_wr  = csr_wr.we && csr_wr.num == CSR_TID;
    assign tcfg_wr = csr_wr.we && csr_wr.num == CSR_TCFG;

    // New TCFG value, also the source of the load value
    assign tcfg_merged = masked_write({tcfg_init, tcfg_periodic, tcfg_en},
                                      csr_wr.wmask, csr_wr.wvalue);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            tid <= '0;
        end
        else if (tid_wr)
        begin
            tid <= masked_write(tid, csr_wr.wmask, csr_wr.wvalue);
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            tcfg_en <= 1'b0;
        end
        else if (tcfg_wr)
        begin
            tcfg_en <= tcfg_merged[0];
        end
    end

    always_ff @(posedge clock)
    begin
        if (tcfg_wr)
        begin
            tcfg_periodic <= tcfg_merged[1];
            tcfg_init     <= tcfg_merged[31:2];
        end
    end

    // Countdown, parks at all ones after a one-shot expiry
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            count <= TIMER_STOPPED;
        end
        else if (tcfg_wr && tcfg_merged[0])
        begin
            count <= {tcfg_merged[31:2], 2'b00};
        end
        else if (tcfg_en && count != TIMER_STOPPED)
        begin
            if (count == '0 && tcfg_periodic)
            begin
                count <= {tcfg_init, 2'b00};
            end
            else
            begin
                count <= count - 32'd1;
            end
        end
    end

    assign tval       = count;
    assign timer_zero = count == '0;

endmodule

// ==== verification/csr_checker.sv ====
`timescale 1ns/1ps

module csr_checker import csr_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  csr_write_t csr_wr,
    input  exc_event_t exc,
    input  logic       ertn_flush,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    input  word_t      csr_rvalue,
    input  logic       has_int,
    input  word_t      ex_entry,
    output int         mismatch_count
);

    // Shadow copy of the architectural state
    word_t     crmd_w;
    word_t     prmd_w;
    word_t     ecfg_w;
    word_t     era;
    word_t     badv;
    word_t     eentry;
    ecode_t    ecode;
    esubcode_t esubcode;
    int_vec_t  is_bits;
    word_t     tid;
    word_t     tcfg_w;
    word_t     count;
    word_t     save [4];

    // Registers without reset are compared only once a value was put in them
    bit prmd_known     = 1'b0;
    bit era_known      = 1'b0;
    bit badv_known     = 1'b0;
    bit eentry_known   = 1'b0;
    bit estat_known    = 1'b0;
    bit tcfg_known     = 1'b0;
    bit save_known [4] = '{default: 1'b0};
    int errors         = 0;

    assign mismatch_count = errors;

    function automatic word_t apply_mask(word_t old_value, word_t mask, word_t value);
        return (old_value & ~mask) | (value & mask);
    endfunction

    function automatic logic writes_to(csr_num_t num);
        return csr_wr.we && csr_wr.num == num;
    endfunction

    function automatic word_t expected_read(csr_num_t num);
        if (num[13:2] == CSR_SAVE0[13:2])
            return save[num[1:0]];
        case (num)
            CSR_CRMD:   return crmd_w;
            CSR_PRMD:   return prmd_w;
            CSR_ECFG:   return ecfg_w;
            CSR_ESTAT:  return {1'b0, esubcode, ecode, 3'b0, is_bits};
            CSR_ERA:    return era;
            CSR_BADV:   return badv;
            CSR_EENTRY: return eentry;
            CSR_TID:    return tid;
            CSR_TCFG:   return tcfg_w;
            CSR_TVAL:   return count;
            default:    return '0;
        endcase
    endfunction

    function automatic bit read_known(csr_num_t num);
        if (num[13:2] == CSR_SAVE0[13:2])
            return save_known[num[1:0]];
        case (num)
            CSR_PRMD:   return prmd_known;
            CSR_ESTAT:  return estat_known;
            CSR_ERA:    return era_known;
            CSR_BADV:   return badv_known;
            CSR_EENTRY: return eentry_known;
            CSR_TCFG:   return tcfg_known;
            default:    return 1'b1;
        endcase
    endfunction

    function automatic logic expected_has_int();
        return (|(is_bits[11:0] & ecfg_w[11:0])) && crmd_w[2];
    endfunction

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
        errors++;
    endtask

    always @(posedge clock)
    begin : shadow_update
        int_vec_t is_next;
        word_t    estat_next;
        word_t    tcfg_next;

        is_next    = is_bits;
        estat_next = apply_mask({19'b0, is_bits}, csr_wr.wmask, csr_wr.wvalue);
        tcfg_next  = apply_mask(tcfg_w, csr_wr.wmask, csr_wr.wvalue);
        if (reset)
        begin
            crmd_w    <= 32'h8;
            ecfg_w    <= '0;
            is_bits   <= '0;
            tid       <= '0;
            tcfg_w[0] <= 1'b0;
            count     <= 32'hffff_ffff;
        end
        else
        begin
            // Exception over ertn over software write
            if (exc.valid)
            begin
                crmd_w[2:0] <= 3'b000;
                prmd_w      <= {29'b0, crmd_w[2:0]};
                era         <= exc.pc;
                ecode       <= exc.ecode;
                esubcode    <= exc.esubcode;
                prmd_known  <= 1'b1;
                era_known   <= 1'b1;
                estat_known <= 1'b1;
                if (exc.ecode == ECODE_ADE || exc.ecode == ECODE_ALE)
                begin
                    badv <= (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF)
                            ? exc.pc : exc.vaddr;
                    badv_known <= 1'b1;
                end
            end
            else if (ertn_flush)
                crmd_w[2:0] <= prmd_w[2:0];
            else if (csr_wr.we)
            begin
                case (csr_wr.num)
                    CSR_CRMD:
                        crmd_w <= apply_mask(crmd_w, csr_wr.wmask, csr_wr.wvalue) & 32'h1f;
                    CSR_PRMD:
                    begin
                        prmd_w     <= apply_mask(prmd_w, csr_wr.wmask, csr_wr.wvalue) & 32'h7;
                        prmd_known <= 1'b1;
                    end
                    CSR_ERA:
                    begin
                        era       <= apply_mask(era, csr_wr.wmask, csr_wr.wvalue);
                        era_known <= 1'b1;
                    end
                    CSR_BADV:
                    begin
                        badv       <= apply_mask(badv, csr_wr.wmask, csr_wr.wvalue);
                        badv_known <= 1'b1;
                    end
                    CSR_EENTRY:
                    begin
                        eentry <= apply_mask(eentry, csr_wr.wmask, csr_wr.wvalue)
                                  & 32'hffff_ffc0;
                        eentry_known <= 1'b1;
                    end
                    default:
                        ;
                endcase
            end

            if (writes_to(CSR_ECFG))
                ecfg_w <= apply_mask(ecfg_w, csr_wr.wmask, csr_wr.wvalue) & 32'h1fff;
            if (writes_to(CSR_ESTAT))
                is_next[1:0] = estat_next[1:0];
            is_next[9:2] = hw_int_in;
            is_next[10]  = 1'b0;
            is_next[12]  = ipi_int_in;
            if (count == '0)
                is_next[11] = 1'b1;
            else if (writes_to(CSR_TICLR) && csr_wr.wmask[0] && csr_wr.wvalue[0])
                is_next[11] = 1'b0;
            is_bits <= is_next;

            if (writes_to(CSR_TID))
                tid <= apply_mask(tid, csr_wr.wmask, csr_wr.wvalue);
            if (writes_to(CSR_TCFG))
            begin
                tcfg_w     <= tcfg_next;
                tcfg_known <= 1'b1;
            end
            // Load on enable, else count down and reload or park
            if (writes_to(CSR_TCFG) && tcfg_next[0])
                count <= {tcfg_next[31:2], 2'b00};
            else if (tcfg_w[0] && count != 32'hffff_ffff)
                count <= (count == '0 && tcfg_w[1]) ? {tcfg_w[31:2], 2'b00} : count - 32'd1;

            if (csr_wr.we && csr_wr.num[13:2] == CSR_SAVE0[13:2])
            begin
                save[csr_wr.num[1:0]] <= apply_mask(save[csr_wr.num[1:0]],
                                                    csr_wr.wmask, csr_wr.wvalue);
                save_known[csr_wr.num[1:0]] <= 1'b1;
            end
        end
    end

    // Outputs are stable by the falling edge
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (read_known(csr_wr.num) && csr_rvalue !== expected_read(csr_wr.num))
                report_mismatch("csr_rvalue", expected_read(csr_wr.num), csr_rvalue);
            if (has_int !== expected_has_int())
                report_mismatch("has_int", {31'b0, expected_has_int()}, {31'b0, has_int});
            if (eentry_known && ex_entry !== eentry)
                report_mismatch("ex_entry", eentry, ex_entry);
        end
    end

endmodule

// ==== verification/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*;
();

    localparam int CLOCK_PERIOD   = 4;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 4;
    // Roughly twice the cycles the tests below take
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clock;
    logic       reset;
    csr_write_t csr_wr;
    word_t      csr_rvalue;
    exc_event_t exc;
    logic       ertn_flush;
    logic [7:0] hw_int_in;
    logic       ipi_int_in;
    logic       has_int;
    word_t      ex_entry;
    int         mismatch_count;
    int         cycle_count = 0;
    word_t      rng = 32'd80127;

    csr_num_t rw_nums [10] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA,
                               CSR_EENTRY, CSR_ECFG, CSR_PRMD, CSR_BADV, CSR_TID};
    csr_num_t conflict_nums [4] = '{CSR_CRMD, CSR_PRMD, CSR_ERA, CSR_BADV};
    csr_num_t unknown_nums [5] = '{14'h2, 14'h8, 14'h43, 14'h100, 14'h3fff};

    csr_unit i_csr_unit (
        .clock      (clock),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .csr_rvalue (csr_rvalue),
        .exc        (exc),
        .ertn_flush (ertn_flush),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .has_int    (has_int),
        .ex_entry   (ex_entry)
    );

    csr_checker i_csr_checker (
        .clock          (clock),
        .reset          (reset),
        .csr_wr         (csr_wr),
        .exc            (exc),
        .ertn_flush     (ertn_flush),
        .hw_int_in      (hw_int_in),
        .ipi_int_in     (ipi_int_in),
        .csr_rvalue     (csr_rvalue),
        .has_int        (has_int),
        .ex_entry       (ex_entry),
        .mismatch_count (mismatch_count)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic word_t xorshift32(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function word_t rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic write_csr(csr_num_t num, word_t mask, word_t value);
        csr_wr = '{1'b1, num, mask, value};
        next_cycle();
        csr_wr.we = 1'b0;
    endtask

    task automatic read_csr(csr_num_t num);
        csr_wr.we  = 1'b0;
        csr_wr.num = num;
        next_cycle();
    endtask

    task automatic print_counts(int timeouts);
        $display("Error counts: mismatches %0d, timeouts %0d", mismatch_count, timeouts);
    endtask

    task automatic exercise_masked_access();
        logic [3:0] idx;

        for (logic [3:0] i = 0; i < 10; i++)
        begin
            write_csr(rw_nums[i], 32'hffff_ffff, rand_word());
            read_csr(rw_nums[i]);
        end
        for (int n = 0; n < 400; n++)
        begin
            idx = 4'(rand_word() % 10);
            write_csr(rw_nums[idx], rand_word(), rand_word());
            read_csr(rw_nums[idx]);
        end
        for (logic [2:0] i = 0; i < 5; i++)
        begin
            write_csr(unknown_nums[i], 32'hffff_ffff, rand_word());
            read_csr(unknown_nums[i]);
        end
        write_csr(CSR_TICLR, 32'hffff_fffe, 32'hffff_ffff);
        read_csr(CSR_TICLR);
    endtask

    task automatic raise_exceptions();
        word_t pick;

        for (int n = 0; n < 60; n++)
        begin
            write_csr(CSR_CRMD, 32'h7, rand_word());
            pick = rand_word();
            exc.valid    = 1'b1;
            exc.ecode    = (pick[1:0] == 2'd0) ? ECODE_ADE :
                           (pick[1:0] == 2'd1) ? ECODE_ALE : pick[13:8];
            exc.esubcode = pick[2] ? ESUBCODE_ADEF : pick[24:16];
            exc.pc       = rand_word();
            exc.vaddr    = rand_word();
            // A write in the same cycle must lose
            csr_wr = '{1'b1, conflict_nums[pick[5:4]], rand_word(), rand_word()};
            next_cycle();
            exc.valid = 1'b0;
            csr_wr.we = 1'b0;
            read_csr(CSR_CRMD);
            read_csr(CSR_PRMD);
            read_csr(CSR_ERA);
            read_csr(CSR_BADV);
            read_csr(CSR_ESTAT);
        end
    endtask

    task automatic return_from_exceptions();
        for (int n = 0; n < 30; n++)
        begin
            write_csr(CSR_PRMD, 32'h7, rand_word());
            write_csr(CSR_CRMD, 32'h7, rand_word());
            ertn_flush = 1'b1;
            csr_wr = '{1'b1, CSR_CRMD, 32'h7, rand_word()};
            next_cycle();
            ertn_flush = 1'b0;
            csr_wr.we  = 1'b0;
            read_csr(CSR_CRMD);
        end
    endtask

    task automatic drive_interrupts();
        word_t pick;

        for (int n = 0; n < 150; n++)
        begin
            pick       = rand_word();
            hw_int_in  = pick[7:0];
            ipi_int_in = pick[8];
            case (pick[10:9])
                2'd0:    write_csr(CSR_ECFG, rand_word(), rand_word());
                2'd1:    write_csr(CSR_ESTAT, rand_word(), rand_word());
                default: write_csr(CSR_CRMD, 32'h4, rand_word());
            endcase
            read_csr(CSR_ESTAT);
        end
        hw_int_in  = 8'h0;
        ipi_int_in = 1'b0;
    endtask

    task automatic run_timer();
        write_csr(CSR_TID, 32'hffff_ffff, rand_word());
        read_csr(CSR_TID);
        write_csr(CSR_TID, rand_word(), rand_word());
        read_csr(CSR_TID);
        // Only the timer line enabled and interrupts on
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'h800);
        write_csr(CSR_CRMD, 32'h4, 32'h4);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        write_csr(CSR_TCFG, 32'hffff_ffff, {30'd5, 1'b0, 1'b1});
        repeat (30) read_csr(CSR_TVAL);
        read_csr(CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h0, 32'h1);
        read_csr(CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT);
        write_csr(CSR_TCFG, 32'hffff_ffff, {30'd3, 1'b1, 1'b1});
        // The clear at n = 12 meets the counter at zero
        for (int n = 0; n < 60; n++)
        begin
            if (n % 12 == 0)
                write_csr(CSR_TICLR, 32'h1, 32'h1);
            else
                read_csr(CSR_TVAL);
        end
        read_csr(CSR_TCFG);
        write_csr(CSR_TCFG, 32'h1, 32'h0);
        repeat (5) read_csr(CSR_TVAL);
        // Back to one-shot with the earlier init
        write_csr(CSR_TCFG, 32'h3, 32'h1);
        repeat (20) read_csr(CSR_TVAL);
        read_csr(CSR_TCFG);
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts(1);
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        reset      = 1'b1;
        csr_wr     = '0;
        exc        = '0;
        ertn_flush = 1'b0;
        hw_int_in  = 8'h0;
        ipi_int_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        read_csr(CSR_CRMD);
        exercise_masked_access();
        raise_exceptions();
        return_from_exceptions();
        drive_interrupts();
        run_timer();
        repeat (4) next_cycle();
        print_counts(0);
        if (mismatch_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/csr_pkg.sv
design/save_regs.sv
design/csr_read_mux.sv
design/int_ctrl.sv
exception/exc_state.sv
timer/stable_timer.sv
design/csr_unit.sv
verification/csr_checker.sv
verification/tb_csr_unit.sv
